/* src/fft_pkg.sv */
/*
 * FFT16 shared definitions
 * Sample format, widths, stage controller types and W16 twiddle table
 */
`default_nettype none

package fft_pkg;

    // ==============================
    // Widths and sizes
    // ==============================
    localparam int DATA_W   = 15;
    localparam int N_POINTS = 16;
    localparam int TW_FRAC  = 13;
    localparam int TW_IDX_W = 3;
    // Sample position inside a frame
    localparam int CNT_W    = $clog2(N_POINTS);
    // Full complex product before scaling
    localparam int MULT_W   = 2 * DATA_W + 1;

    // One complex sample, real part in the upper half
    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_t;

    // W16^n for n = 0..7, Q1.13
    localparam cplx_t tw_rom [1 << TW_IDX_W] = '{
        '{re:  15'sd8192, im:  15'sd0},
        '{re:  15'sd7568, im: -15'sd3135},
        '{re:  15'sd5793, im: -15'sd5793},
        '{re:  15'sd3135, im: -15'sd7568},
        '{re:  15'sd0,    im: -15'sd8192},
        '{re: -15'sd3135, im: -15'sd7568},
        '{re: -15'sd5793, im: -15'sd5793},
        '{re: -15'sd7568, im: -15'sd3135}
    };

    // Stage sequencer phases
    typedef enum logic [1:0] {IDLE, FILL, COMPUTE, DRAIN} ctrl_state_e;

    // Controller to datapath, valid for the current cycle
    typedef struct packed {
        logic                compute;
        logic                load;
        logic [TW_IDX_W-1:0] tw_idx;
    } stage_ctrl_t;

endpackage

`default_nettype wire

/* src/sdf_butterfly.sv */
/*
 * Radix-2 butterfly
 * Half sum and half difference, scaled so no output overflows
 */
`timescale 1ns/1ps
`default_nettype none

module sdf_butterfly (
    input  fft_pkg::cplx_t a_i,
    input  fft_pkg::cplx_t b_i,
    output fft_pkg::cplx_t sum_o,
    output fft_pkg::cplx_t diff_o
);
    import fft_pkg::*;

    // One guard bit on every part
    logic signed [DATA_W:0] a_re, a_im;
    logic signed [DATA_W:0] b_re, b_im;
    logic signed [DATA_W:0] s_re, s_im;
    logic signed [DATA_W:0] d_re, d_im;

    always_comb begin
        // Sign extension
        a_re = {a_i.re[DATA_W-1], a_i.re};
        a_im = {a_i.im[DATA_W-1], a_i.im};
        b_re = {b_i.re[DATA_W-1], b_i.re};
        b_im = {b_i.im[DATA_W-1], b_i.im};

        s_re = a_re + b_re;
        s_im = a_im + b_im;
        d_re = a_re - b_re;
        d_im = a_im - b_im;

        // Arithmetic shift by one, drop the LSB
        sum_o.re  = s_re[DATA_W:1];
        sum_o.im  = s_im[DATA_W:1];
        diff_o.re = d_re[DATA_W:1];
        diff_o.im = d_im[DATA_W:1];
    end

endmodule

`default_nettype wire

/* src/sdf_delay_line.sv */
/*
 * SDF feedback delay line
 * DEPTH complex samples, shifts only when enabled
 */
`timescale 1ns/1ps
`default_nettype none

module sdf_delay_line #(
    parameter int DEPTH = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           shift_i,
    input  fft_pkg::cplx_t data_i,
    output fft_pkg::cplx_t data_o
);
    import fft_pkg::*;

    // Entry 0 is newest
    cplx_t mem_q [DEPTH];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (shift_i) begin
            mem_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                mem_q[i] <= mem_q[i-1];
            end
        end
    end

    // Oldest entry, written DEPTH shifts ago
    assign data_o = mem_q[DEPTH-1];

endmodule

`default_nettype wire

/* src/twiddle_mult.sv */
/*
 * Twiddle multiplier
 * Complex product with a W16 table entry, truncated to DATA_W with saturation
 */
`timescale 1ns/1ps
`default_nettype none

module twiddle_mult (
    input  fft_pkg::cplx_t                data_i,
    input  logic [fft_pkg::TW_IDX_W-1:0]  tw_idx_i,
    output fft_pkg::cplx_t                data_o
);
    import fft_pkg::*;

    cplx_t                    tw;
    logic signed [MULT_W-1:0] d_re, d_im;
    logic signed [MULT_W-1:0] w_re, w_im;
    logic signed [MULT_W-1:0] prod_re, prod_im;
    logic signed [MULT_W-1:0] shr_re, shr_im;

    // Clamp to the signed DATA_W range
    function automatic logic signed [DATA_W-1:0] sat(input logic signed [MULT_W-1:0] v);
        logic fits;
        // Fits when all bits above the result are copies of its sign
        fits = (&v[MULT_W-1:DATA_W-1]) || !(|v[MULT_W-1:DATA_W-1]);
        if (fits) begin
            return v[DATA_W-1:0];
        end else if (v[MULT_W-1]) begin
            return {1'b1, {(DATA_W-1){1'b0}}};
        end else begin
            return {1'b0, {(DATA_W-1){1'b1}}};
        end
    endfunction

    always_comb begin
        tw = tw_rom[tw_idx_i];

        // Widen all operands before the multiply
        d_re = MULT_W'($signed(data_i.re));
        d_im = MULT_W'($signed(data_i.im));
        w_re = MULT_W'($signed(tw.re));
        w_im = MULT_W'($signed(tw.im));

        // (a + jb)(c + jd)
        prod_re = d_re * w_re - d_im * w_im;
        prod_im = d_re * w_im + d_im * w_re;

        // Drop Q1.13 fraction, floor rounding
        shr_re = prod_re >>> TW_FRAC;
        shr_im = prod_im >>> TW_FRAC;

        data_o.re = sat(shr_re);
        data_o.im = sat(shr_im);
    end

endmodule

`default_nettype wire

/* src/sdf_stage_ctrl.sv */
/*
 * SDF stage controller
 * Tracks the frame position, selects fill/compute, hands out twiddle index
 */
`timescale 1ns/1ps
`default_nettype none

module sdf_stage_ctrl #(
    parameter int DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_i,
    output fft_pkg::stage_ctrl_t ctrl_o,
    output logic                 valid_o
);
    import fft_pkg::*;

    ctrl_state_e            state_q, state_d, next_ph;
    logic       [CNT_W-1:0] cnt_q, cnt_d, cnt_inc;
    logic [TW_IDX_W-1:0]    tw_idx;
    logic                   diff_pend_q, diff_pend_d;
    logic                   valid_q, valid_d;

    assign cnt_inc = cnt_q + 1'b1;
    // Phase of the next sample, odd D-block is compute
    assign next_ph = cnt_inc[$clog2(DEPTH)] ? COMPUTE : FILL;
    // (k mod D) * (8/D)
    assign tw_idx  = TW_IDX_W'((int'(cnt_q) % DEPTH) * (N_POINTS / 2 / DEPTH));

    always_comb begin
        state_d     = state_q;
        cnt_d       = cnt_q;
        diff_pend_d = diff_pend_q;
        valid_d     = 1'b0;
        ctrl_o      = '0;
        case (state_q)
            IDLE: begin
                cnt_d       = '0;
                diff_pend_d = 1'b0;
                // Sample 0 of a new frame, always a fill slot
                if (valid_i) begin
                    ctrl_o.load = 1'b1;
                    cnt_d       = cnt_inc;
                    state_d     = next_ph;
                end
            end
            FILL: begin
                ctrl_o.load   = 1'b1;
                ctrl_o.tw_idx = tw_idx;
                // Differences of the previous group leave through the twiddle
                valid_d       = diff_pend_q;
                cnt_d         = cnt_inc;
                state_d       = next_ph;
            end
            COMPUTE: begin
                ctrl_o.load    = 1'b1;
                ctrl_o.compute = 1'b1;
                valid_d        = 1'b1;
                diff_pend_d    = 1'b1;
                cnt_d          = cnt_inc;
                // Last frame sample, counter wraps to 0 for the drain
                if (cnt_q == '1) begin
                    state_d = DRAIN;
                end else begin
                    state_d = next_ph;
                end
            end
            DRAIN: begin
                ctrl_o.load   = 1'b1;
                ctrl_o.tw_idx = tw_idx;
                valid_d       = 1'b1;
                cnt_d         = cnt_inc;
                if (cnt_q == CNT_W'(DEPTH - 1)) begin
                    state_d = IDLE;
                    cnt_d   = '0;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            diff_pend_q <= 1'b0;
            valid_q     <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            diff_pend_q <= diff_pend_d;
            valid_q     <= valid_d;
        end
    end

    // Lines up with the stage output register
    assign valid_o = valid_q;

endmodule

`default_nettype wire

/* src/sdf_stage.sv */
/*
 * One radix-2 SDF stage
 * Controller, feedback delay line, butterfly, twiddle and output register
 */
`timescale 1ns/1ps
`default_nettype none

module sdf_stage #(
    parameter int DEPTH = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           valid_i,
    input  fft_pkg::cplx_t data_i,
    output logic           valid_o,
    output fft_pkg::cplx_t data_o
);
    import fft_pkg::*;

    stage_ctrl_t ctrl;
    cplx_t       dly_in;
    cplx_t       dly_out;
    cplx_t       bf_sum;
    cplx_t       bf_diff;
    cplx_t       tw_out;
    cplx_t       out_d;

    // ==============================
    // Sequencing
    // ==============================
    sdf_stage_ctrl #(
        .DEPTH (DEPTH)
    ) u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .ctrl_o  (ctrl),
        .valid_o (valid_o)
    );

    // ==============================
    // Datapath
    // ==============================

    // Fill stores the input, compute stores the difference
    assign dly_in = ctrl.compute ? bf_diff : data_i;

    sdf_delay_line #(
        .DEPTH (DEPTH)
    ) u_dly (
        .clk     (clk),
        .rst     (rst),
        .shift_i (ctrl.load),
        .data_i  (dly_in),
        .data_o  (dly_out)
    );

    // Older sample is a, current input is b
    sdf_butterfly u_bf (
        .a_i    (dly_out),
        .b_i    (data_i),
        .sum_o  (bf_sum),
        .diff_o (bf_diff)
    );

    // Only the stored differences get rotated
    twiddle_mult u_tw (
        .data_i   (dly_out),
        .tw_idx_i (ctrl.tw_idx),
        .data_o   (tw_out)
    );

    // Sum leaves at once, differences one half-group later
    assign out_d = ctrl.compute ? bf_sum : tw_out;

    // Output register, holds its value between frames
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_o <= '0;
        end else if (ctrl.load) begin
            data_o <= out_d;
        end
    end

endmodule

`default_nettype wire

/* src/fft16_top.sv */
/*
 * 16-point radix-2 DIF SDF FFT
 * Four stages of depth 8, 4, 2, 1; output in bit-reversed order
 */
`timescale 1ns/1ps
`default_nettype none

module fft16_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           valid_i,
    input  fft_pkg::cplx_t data_i,
    output logic           valid_o,
    output fft_pkg::cplx_t data_o
);
    import fft_pkg::*;

    // Inter-stage links
    logic  v8, v4, v2;
    cplx_t d8, d4, d2;

    // Stage 1, pairs k and k+8
    sdf_stage #(.DEPTH(8)) u_stage8 (
        .clk (clk), .rst (rst),
        .valid_i (valid_i), .data_i (data_i),
        .valid_o (v8),      .data_o (d8)
    );

    // Stage 2, pairs k and k+4
    sdf_stage #(.DEPTH(4)) u_stage4 (
        .clk (clk), .rst (rst),
        .valid_i (v8), .data_i (d8),
        .valid_o (v4), .data_o (d4)
    );

    // Stage 3, pairs k and k+2
    sdf_stage #(.DEPTH(2)) u_stage2 (
        .clk (clk), .rst (rst),
        .valid_i (v4), .data_i (d4),
        .valid_o (v2), .data_o (d2)
    );

    // Stage 4, adjacent pairs, twiddle is always W^0
    sdf_stage #(.DEPTH(1)) u_stage1 (
        .clk (clk), .rst (rst),
        .valid_i (v2),      .data_i (d2),
        .valid_o (valid_o), .data_o (data_o)
    );

endmodule

`default_nettype wire

/* testbench/fft16_assertions.sv */
/*
 * FFT16 valid timing checks, bound to the top level
 */
`timescale 1ns/1ps
`default_nettype none

module fft16_assertions (
    input logic clk,
    input logic rst,
    input logic valid_i,
    input logic valid_o
);
    int fail_cnt = 0;

    // Nothing survives a reset, no output before a fresh frame crosses all stages
    a_rst_quiet: assert property (@(posedge clk) !rst |=> !valid_o [*19])
        else begin
            $error("valid_o high within 19 cycles after a reset cycle");
            fail_cnt++;
        end

    // First output 19 cycles after the first input of a frame
    a_latency: assert property (@(posedge clk) disable iff (!rst)
        $rose(valid_i) |-> ##19 $rose(valid_o))
        else begin
            $error("first output of a frame not 19 cycles after its first input");
            fail_cnt++;
        end

    // Output frame ends after exactly 16 samples
    a_run_end: assert property (@(posedge clk) disable iff (!rst)
        $rose(valid_o) |-> ##16 !valid_o)
        else begin
            $error("valid_o still high 16 cycles after it rose");
            fail_cnt++;
        end

    // And it was high for all of them
    a_run_len: assert property (@(posedge clk) disable iff (!rst)
        $fell(valid_o) |-> $past(valid_o, 16))
        else begin
            $error("output frame shorter than 16 samples");
            fail_cnt++;
        end

endmodule

bind fft16_top fft16_assertions u_assert (
    .clk     (clk),
    .rst     (rst),
    .valid_i (valid_i),
    .valid_o (valid_o)
);

`default_nettype wire

/* testbench/fft16_checker.sv */
/*
 * FFT16 output checker
 * Fixed-point DIF model of every input frame, compared with the DUT stream
 */
`timescale 1ns/1ps
`default_nettype none

module fft16_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           valid_i,
    input  fft_pkg::cplx_t data_i,
    input  logic           valid_o,
    input  fft_pkg::cplx_t data_o,
    output int             err_cnt_o,
    output int             frames_in_o,
    output int             frames_out_o,
    output logic           busy_o
);
    import fft_pkg::*;

    int   tw_re [N_POINTS/2];
    int   tw_im [N_POINTS/2];
    int   in_re [N_POINTS];
    int   in_im [N_POINTS];
    int   exp_re_q [$];
    int   exp_im_q [$];
    int   start_q [$];
    int   in_cnt, run_len, pending, cycle, lat;
    int   err_cnt, frames_in, frames_out;
    logic out_seen, rst_q;

    assign err_cnt_o    = err_cnt;
    assign frames_in_o  = frames_in;
    assign frames_out_o = frames_out;

    function automatic int round_int(input real v);
        if (v < 0.0) begin
            return -$rtoi(0.5 - v);
        end
        return $rtoi(v + 0.5);
    endfunction

    // Signed DATA_W range
    function automatic int clamp(input int v);
        if (v > (1 << (DATA_W - 1)) - 1) begin
            return (1 << (DATA_W - 1)) - 1;
        end else if (v < -(1 << (DATA_W - 1))) begin
            return -(1 << (DATA_W - 1));
        end
        return v;
    endfunction

    // ==============================
    // Reference model
    // ==============================
    task automatic run_model();
        int a_re [N_POINTS];
        int a_im [N_POINTS];
        int p, q, idx, dr, di;
        a_re = in_re;
        a_im = in_im;
        for (int d = N_POINTS / 2; d >= 1; d = d / 2) begin
            for (int g = 0; g < N_POINTS; g += 2 * d) begin
                for (int k = 0; k < d; k++) begin
                    p   = g + k;
                    q   = p + d;
                    idx = k * (N_POINTS / 2 / d);
                    dr  = (a_re[p] - a_re[q]) >>> 1;
                    di  = (a_im[p] - a_im[q]) >>> 1;
                    a_re[p] = (a_re[p] + a_re[q]) >>> 1;
                    a_im[p] = (a_im[p] + a_im[q]) >>> 1;
                    a_re[q] = clamp((dr * tw_re[idx] - di * tw_im[idx]) >>> TW_FRAC);
                    a_im[q] = clamp((dr * tw_im[idx] + di * tw_re[idx]) >>> TW_FRAC);
                end
            end
        end
        // In-place order is the stream order, bins come out bit-reversed
        for (int j = 0; j < N_POINTS; j++) begin
            exp_re_q.push_back(a_re[j]);
            exp_im_q.push_back(a_im[j]);
        end
    endtask

    initial begin
        real ang;
        // W16^n straight from its definition
        for (int n = 0; n < N_POINTS / 2; n++) begin
            ang      = 2.0 * 3.14159265358979 * n / N_POINTS;
            tw_re[n] = round_int($cos(ang) * real'(1 << TW_FRAC));
            tw_im[n] = round_int(-$sin(ang) * real'(1 << TW_FRAC));
        end
        {in_cnt, run_len, pending, cycle} = '0;
        {err_cnt, frames_in, frames_out} = '0;
        out_seen = 1'b0;
        rst_q    = 1'b1;
        busy_o   = 1'b0;
    end

    always @(posedge clk) begin
        cycle++;
        if (!rst) begin
            if (!rst_q && (valid_o || data_o != '0)) begin
                $display("ERR %0t: valid_o or data_o not cleared during reset", $time);
                err_cnt++;
            end
            // Frames in flight are lost
            frames_in -= pending;
            {pending, in_cnt, run_len} = '0;
            out_seen = 1'b0;
            exp_re_q.delete();
            exp_im_q.delete();
            start_q.delete();
        end else begin
            // Input side, one model run per complete frame
            if (valid_i) begin
                if (in_cnt == 0) begin
                    start_q.push_back(cycle);
                end
                in_re[in_cnt] = int'(data_i.re);
                in_im[in_cnt] = int'(data_i.im);
                in_cnt++;
                if (in_cnt == N_POINTS) begin
                    run_model();
                    in_cnt = 0;
                    frames_in++;
                    pending++;
                end
            end
            // Output side
            if (valid_o) begin
                if (run_len == 0) begin
                    lat = (start_q.size() != 0) ? cycle - start_q.pop_front() : -1;
                    if (lat != 19) begin
                        $display("ERR %0t: frame latency %0d cycles, expected 19", $time, lat);
                        err_cnt++;
                    end
                end
                if (exp_re_q.size() == 0) begin
                    $display("ERR %0t: valid_o high with no frame pending", $time);
                    err_cnt++;
                end else begin
                    if (int'(data_o.re) != exp_re_q[0] || int'(data_o.im) != exp_im_q[0]) begin
                        $display("ERR %0t: frame %0d sample %0d got (%0d,%0d) expected (%0d,%0d)",
                                 $time, frames_out, run_len, int'(data_o.re), int'(data_o.im),
                                 exp_re_q[0], exp_im_q[0]);
                        err_cnt++;
                    end
                    void'(exp_re_q.pop_front());
                    void'(exp_im_q.pop_front());
                end
                run_len++;
                out_seen = 1'b1;
                if (run_len == N_POINTS) begin
                    frames_out++;
                    pending--;
                end
            end else begin
                if (run_len != 0 && run_len != N_POINTS) begin
                    $display("ERR %0t: output frame of %0d samples, expected 16", $time, run_len);
                    err_cnt++;
                end
                run_len = 0;
                if (!out_seen && data_o != '0) begin
                    $display("ERR %0t: data_o not zero before the first output", $time);
                    err_cnt++;
                end
            end
        end
        rst_q = rst;
        busy_o <= (pending != 0) || (in_cnt != 0);
    end

endmodule

`default_nettype wire

/* testbench/tb_fft16.sv */
/*
 * FFT16 testbench
 * Directed and random frames, mid-frame reset, closing summary
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fft16;
    import fft_pkg::*;

    logic  clk;
    logic  rst;
    logic  valid_i;
    cplx_t data_i;
    logic  valid_o;
    cplx_t data_o;
    logic  busy;
    int    seed;
    int    timeouts;
    int    total;
    int    err_cnt, frames_in, frames_out;
    cplx_t frame_buf [N_POINTS];

    fft16_top DUT (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

    fft16_checker u_check (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .data_i       (data_i),
        .valid_o      (valid_o),
        .data_o       (data_o),
        .err_cnt_o    (err_cnt),
        .frames_in_o  (frames_in),
        .frames_out_o (frames_out),
        .busy_o       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Kind 0 random, 1 impulse, 2 constant, 3 full-scale step, 4 full-scale alternating
    task automatic fill_frame(input int kind);
        for (int i = 0; i < N_POINTS; i++) begin
            case (kind)
                1: frame_buf[i] = (i == 0) ? {15'sd8191, 15'sd0} : '0;
                2: frame_buf[i] = {15'sd4000, -15'sd3000};
                3: frame_buf[i] = (i < 8) ? {15'h3fff, 15'h3fff} : {15'h4000, 15'h4000};
                4: frame_buf[i] = i[0] ? {15'h4000, 15'h3fff} : {15'h3fff, 15'h4000};
                default: begin
                    frame_buf[i].re = DATA_W'($random(seed));
                    frame_buf[i].im = DATA_W'($random(seed));
                end
            endcase
        end
    endtask

    task automatic send_samples(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            valid_i <= 1'b1;
            data_i  <= frame_buf[i];
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 1'b0;
            data_i  <= '0;
        end
    endtask

    task automatic send_frame(input int kind, input int gap);
        fill_frame(kind);
        send_samples(N_POINTS);
        idle_cycles(gap);
    endtask

    task automatic wait_drain(input int limit);
        int t;
        t = 0;
        while (busy && t < limit) begin
            @(posedge clk);
            t++;
        end
        if (busy) begin
            $display("Timeout: DUT still had frames in flight after %0d cycles", limit);
            timeouts++;
        end
    endtask

    initial begin
        seed     = 32'h78b3_5dac;
        timeouts = 0;
        rst      = 1'b0;
        valid_i  = 1'b0;
        data_i   = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        idle_cycles(6);

        // Directed frames, then back-to-back random frames at the minimum gap
        for (int k = 1; k <= 4; k++) begin
            send_frame(k, 8);
        end
        for (int k = 0; k < 6; k++) begin
            send_frame(0, 8);
        end
        for (int k = 0; k < 20; k++) begin
            send_frame(0, 8 + int'($unsigned($random(seed)) % 13));
        end
        wait_drain(100);

        // Reset while one frame leaves and the next one enters
        send_frame(0, 8);
        fill_frame(0);
        send_samples(5);
        @(posedge clk);
        rst     <= 1'b0;
        valid_i <= 1'b0;
        data_i  <= '0;
        idle_cycles(10);
        rst <= 1'b1;
        idle_cycles(4);
        send_frame(0, 8);
        send_frame(0, 8);
        wait_drain(100);
        idle_cycles(4);

        total = err_cnt + timeouts + DUT.u_assert.fail_cnt;
        if (frames_in != frames_out) begin
            $display("Output frame count does not match input frame count");
            total++;
        end
        $display("Summary: %0d frames in, %0d out, %0d check errors, %0d assertion failures, %0d timeouts",
                 frames_in, frames_out, err_cnt, DUT.u_assert.fail_cnt, timeouts);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/fft_pkg.sv
src/sdf_butterfly.sv
src/sdf_delay_line.sv
src/twiddle_mult.sv
src/sdf_stage_ctrl.sv
src/sdf_stage.sv
src/fft16_top.sv
testbench/fft16_assertions.sv
testbench/fft16_checker.sv
testbench/tb_fft16.sv

/* run.sh */
#!/bin/sh
# Build and run the FFT16 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_fft16 -f all.f
./obj_dir/Vtb_fft16 +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
